//--- src.f
+incdir+include
source/asg_pkg.sv
source/asg_regs.sv
source/asg_channel.sv
source/asg_linear.sv
source/asg_top.sv
verif/asg_properties.sv
verif/asg_tb.sv

//--- verif/asg_tb.sv
//////////////////////////////
// signal generator testbench
// APB setup, table driven playback
// checked against a pointer model
//////////////////////////////

`timescale 1ns/1ps
`include "asg_defs.svh"

module asg_tb import asg_pkg::*; ();

  // one stimulus row, src 0 is software, else external bit plus one
  typedef struct packed {
    logic [2:0] ch;
    asg_ptr_t   siz;
    asg_ptr_t   off;
    asg_ptr_t   stp;
    logic       wrap;
    asg_mul_t   mul;
    asg_sum_t   sum;
    logic [1:0] src;
    int         n;
  } row_t;

  logic bus;
  logic arst_n;
  logic psel;
  logic penable;
  logic pwrite;
  logic [15:0] paddr;
  asg_word_u pwdata;
  asg_word_u prdata;
  logic pready;
  logic pslverr;
  logic [`ASG_TN-1:0] trg_ext;
  logic [`ASG_CH_N-1:0] trg_out;
  asg_smp_t dac_dat [`ASG_CH_N];
  logic [`ASG_CH_N-1:0] dac_vld;

  row_t rows [8];
  int nrow;
  // local copy of the waveform and the model output
  asg_smp_t tbl [2**`ASG_CWM];
  asg_smp_t exp_dat [129];
  logic exp_end [129];
  int seed;
  int errors;
  int checks;
  int wd_cycles;

  asg_top asg_top_inst (
    .bus     (bus),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .trg_ext (trg_ext),
    .trg_out (trg_out),
    .dac_dat (dac_dat),
    .dac_vld (dac_vld)
  );

  // 20 ns period
  always #10 bus = ~bus;

  //////////////////////////////
  // address helpers and model
  //////////////////////////////

  function automatic logic [15:0] reg_addr(input logic [2:0] ch, input logic [11:0] off);
    return {ch, 1'b0, off};
  endfunction

  function automatic logic [15:0] tbl_addr(input logic [2:0] ch, input int idx);
    return {ch, 1'b1, 2'b00, 8'(idx), 2'b00};
  endfunction

  // gain, shift back to unity, offset, clamp to full scale
  function automatic asg_smp_t scale(input asg_smp_t s, input asg_mul_t m, input asg_sum_t o);
    int v;
    v = (int'(s) * int'(m)) >>> (`ASG_MW - 2);
    v = v + int'(o);
    if (v > (1 << (`ASG_DW - 1)) - 1) begin
      v = (1 << (`ASG_DW - 1)) - 1;
    end else if (v < -(1 << (`ASG_DW - 1))) begin
      v = -(1 << (`ASG_DW - 1));
    end
    return asg_smp_t'(v);
  endfunction

  // register map walk for read back
  function automatic logic [11:0] test_reg(input int i);
    case (i)
      0: return `ASG_REG_TRG;
      1: return `ASG_REG_SIZ;
      2: return `ASG_REG_OFF;
      3: return `ASG_REG_STP;
      4: return `ASG_REG_MOD;
      5: return `ASG_REG_MUL;
      default: return `ASG_REG_SUM;
    endcase
  endfunction

  function automatic logic [31:0] test_val(input int i, input int ch);
    case (i)
      0: return 32'(1 + ch);
      1: return 32'hA5C3 - ch;
      2: return 32'h1234 + ch;
      3: return 32'h0F0F + ch;
      4: return 32'h1;
      5: return 32'h3A5A - ch;
      default: return 32'h0155 + ch;
    endcase
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_smp(input string name, input asg_smp_t exp, input asg_smp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s exp=%0d act=%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input asg_word_u exp, input asg_word_u act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
    end
  endtask

  //////////////////////////////
  // bus tasks
  //////////////////////////////

  // setup, access, then one idle cycle
  task automatic apb_xfer(input logic wr, input logic [15:0] addr, input asg_word_u wd,
                          input logic exp_err, output asg_word_u rd);
    @(negedge bus);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wd;
    @(negedge bus);
    penable = 1'b1;
    // response sampled just before the completing edge
    @(posedge bus);
    rd = prdata;
    check_bit("pready", 1'b1, pready);
    check_bit("pslverr", exp_err, pslverr);
    @(negedge bus);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_write(input int ch, input logic [11:0] off, input logic [31:0] val);
    asg_word_u rd;
    apb_xfer(1'b1, reg_addr(3'(ch), off), val, 1'b0, rd);
  endtask

  task automatic reg_read(input int ch, input logic [11:0] off, input logic [31:0] exp);
    asg_word_u rd;
    apb_xfer(1'b0, reg_addr(3'(ch), off), '0, 1'b0, rd);
    check_word("prdata", exp, rd);
  endtask

  task automatic pulse_ext(input logic [`ASG_TN-1:0] mask);
    @(negedge bus);
    trg_ext = mask;
    @(negedge bus);
    trg_ext = '0;
  endtask

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  task automatic add_row(input int ch, input asg_ptr_t siz, input asg_ptr_t off,
                         input asg_ptr_t stp, input logic wrap, input asg_mul_t mul,
                         input asg_sum_t sum, input int src, input int n);
    rows[nrow] = '{3'(ch), siz, off, stp, wrap, mul, sum, 2'(src), n};
    wd_cycles = wd_cycles + n + 400;
    nrow++;
  endtask

  task automatic load_rows();
    // wrap, fractional step
    add_row(0, 16'h2800, 16'h0300, 16'h0180, 1'b1, 16'h4000, 14'h0000, 0, 60);
    // one shot, ceil((0x2000-0x80)/0x340)
    add_row(1, 16'h2000, 16'h0080, 16'h0340, 1'b0, 16'h4000, 14'h0010, 0, 10);
    // external bit 1, half gain, negative offset
    add_row(1, 16'h1800, 16'h0000, 16'h0100, 1'b1, 16'h2000, 14'h3F9C, 2, 40);
    // external bit 0, near double gain saturates
    add_row(0, 16'h1000, 16'h0040, 16'h00C0, 1'b0, 16'h7FFF, 14'h07D0, 1, 21);
    // gain of minus two, offset at negative full scale
    add_row(1, 16'h3000, 16'h0000, 16'h0200, 1'b1, 16'h8000, 14'h2000, 0, 50);
  endtask

  // expected samples and end flags, one entry past the row length
  task automatic build_model(input row_t r);
    int p;
    int nxt;
    logic live;
    int last;
    p = int'(r.off);
    live = 1'b1;
    last = -1;
    for (int k = 0; k <= r.n; k++) begin
      exp_dat[k] = scale(tbl[p >> `ASG_CWF], r.mul, r.sum);
      nxt = p + int'(r.stp);
      exp_end[k] = live && (nxt >= int'(r.siz));
      if (exp_end[k] && r.wrap) begin
        p = nxt - int'(r.siz);
      end else if (exp_end[k]) begin
        live = 1'b0;
        last = k;
      end else if (live) begin
        p = nxt;
      end
    end
    if (!r.wrap && last != r.n - 1) begin
      errors++;
      $display("one shot sample count in the table does not match the pointer model");
    end
  endtask

  //////////////////////////////
  // test sequences
  //////////////////////////////

  task automatic reg_test();
    asg_word_u rd;
    for (int ch = 0; ch < `ASG_CH_N; ch++) begin
      // reset values, gain at unity
      reg_read(ch, `ASG_REG_MUL, 32'(1 << (`ASG_MW - 2)));
      reg_read(ch, `ASG_REG_SIZ, 32'h0);
      for (int i = 0; i < 7; i++) begin
        reg_write(ch, test_reg(i), test_val(i, ch));
      end
    end
    // bad channel must not alias onto channel 0
    apb_xfer(1'b1, reg_addr(3'(`ASG_CH_N), `ASG_REG_SIZ), 32'hFFFF, 1'b1, rd);
    apb_xfer(1'b0, reg_addr(3'd0, 12'h008), '0, 1'b1, rd);
    apb_xfer(1'b1, reg_addr(3'd1, 12'h03C), 32'h1, 1'b1, rd);
    for (int ch = 0; ch < `ASG_CH_N; ch++) begin
      for (int i = 0; i < 7; i++) begin
        reg_read(ch, test_reg(i), test_val(i, ch));
      end
      // write only table
      apb_xfer(1'b0, tbl_addr(3'(ch), 5), '0, 1'b0, rd);
      check_word("prdata", '0, rd);
      reg_write(ch, `ASG_REG_TRG, 32'h0);
    end
  endtask

  task automatic run_row(input int idx);
    row_t r;
    asg_word_u wd;
    asg_word_u rd;
    logic [`ASG_TN-1:0] mask;
    int other;
    int cyc;
    r = rows[idx];
    other = (r.ch + 1) % `ASG_CH_N;
    mask = '0;
    if (r.src != 0) begin
      mask[r.src - 1] = 1'b1;
    end
    // random waveform over the used part of the table
    for (int k = 0; k <= int'((r.siz - 1) >> `ASG_CWF); k++) begin
      tbl[k] = asg_smp_t'($random(seed));
      wd = '0;
      wd.smp.dat = tbl[k];
      apb_xfer(1'b1, tbl_addr(r.ch, k), wd, 1'b0, rd);
    end
    reg_write(r.ch, `ASG_REG_SIZ, 32'(r.siz));
    reg_write(r.ch, `ASG_REG_OFF, 32'(r.off));
    reg_write(r.ch, `ASG_REG_STP, 32'(r.stp));
    reg_write(r.ch, `ASG_REG_MOD, 32'(r.wrap));
    reg_write(r.ch, `ASG_REG_MUL, 32'(r.mul));
    reg_write(r.ch, `ASG_REG_SUM, 32'(r.sum));
    reg_write(r.ch, `ASG_REG_TRG, 32'(mask));
    build_model(r);
    if (r.src == 0) begin
      wd = '0;
      wd.ctl.trg = 1'b1;
      apb_xfer(1'b1, reg_addr(r.ch, `ASG_REG_CTL), wd, 1'b0, rd);
    end else begin
      // unmasked bit, channel stays idle
      pulse_ext(~mask);
      repeat (4) begin
        @(negedge bus);
        check_bit("dac_vld", 1'b0, dac_vld[r.ch]);
      end
      pulse_ext(mask);
    end
    // count cycles from the trigger edge
    cyc = 0;
    while (!dac_vld[r.ch] && cyc < 8) begin
      @(negedge bus);
      cyc++;
    end
    if (!dac_vld[r.ch]) begin
      errors++;
      $display("channel %0d gave no output after its trigger", r.ch);
    end else begin
      checks++;
      if (cyc != 2) begin
        errors++;
        $display("ERR %0t trigger_latency exp=2 act=%0d", $time, cyc);
      end
      // trg_out leads the dac stream by one sample
      for (int k = 0; k < r.n; k++) begin
        check_bit("dac_vld", 1'b1, dac_vld[r.ch]);
        check_smp("dac_dat", exp_dat[k], dac_dat[r.ch]);
        check_bit("trg_out", exp_end[k + 1], trg_out[r.ch]);
        check_bit("dac_vld_other", 1'b0, dac_vld[other]);
        @(negedge bus);
      end
    end
    if (!r.wrap) begin
      check_bit("dac_vld", 1'b0, dac_vld[r.ch]);
    end
    // channel reset, output gone one cycle later
    wd = '0;
    wd.ctl.rst = 1'b1;
    apb_xfer(1'b1, reg_addr(r.ch, `ASG_REG_CTL), wd, 1'b0, rd);
    @(negedge bus);
    check_bit("dac_vld", 1'b0, dac_vld[r.ch]);
    reg_write(r.ch, `ASG_REG_TRG, 32'h0);
  endtask

  //////////////////////////////
  // main sequence and watchdog
  //////////////////////////////

  initial begin
    bus = 1'b0;
    arst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    trg_ext = '0;
    seed = 96;
    errors = 0;
    checks = 0;
    wd_cycles = 0;
    nrow = 0;
    repeat (5) @(negedge bus);
    arst_n = 1'b1;
    check_bit("pready", 1'b0, pready);
    load_rows();
    reg_test();
    for (int i = 0; i < nrow; i++) begin
      run_row(i);
    end
    @(negedge bus);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // budget is rows times (samples plus setup), one clock period each
  initial begin
    wait (wd_cycles != 0);
    #(wd_cycles * 20);
    $display("timeout, the tests did not complete in the expected time");
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- verif/asg_properties.sv
//////////////////////////////
// signal generator assertions
// APB response and output pulses
//////////////////////////////

`timescale 1ns/1ps
`include "asg_defs.svh"

module asg_properties (
  input logic                 bus,
  input logic                 arst_n,
  input logic                 psel,
  input logic                 penable,
  input logic                 pready,
  input logic                 pslverr,
  input logic [`ASG_CH_N-1:0] dac_vld,
  input logic [`ASG_CH_N-1:0] trg_out
);

  // zero wait states, ready only in an access cycle after its setup cycle
  apb_rdy: assert property (@(posedge bus) disable iff (!arst_n)
    pready |-> (psel && penable && $past(psel && !penable)))
    else $error("pready outside an APB access cycle");

  // error response only in a complete transfer
  apb_err: assert property (@(posedge bus) disable iff (!arst_n)
    pslverr |-> (pready && $past(psel && !penable)))
    else $error("pslverr outside an APB access cycle");

  // no output while in reset, nor in the first cycle after it
  rst_vld: assert property (@(posedge bus)
    !arst_n |=> (dac_vld == '0))
    else $error("dac_vld high during reset");

  // end of table is a single cycle pulse
  for (genvar i = 0; i < `ASG_CH_N; i++) begin : g_trg
    trg_one: assert property (@(posedge bus) disable iff (!arst_n)
      trg_out[i] |=> !trg_out[i])
      else $error("trg_out longer than one cycle");
  end

endmodule

bind asg_top asg_properties asg_properties_inst (.*);

//--- source/asg_top.sv
//////////////////////////////
// multichannel signal generator
// register bank, playback channels
// and the shared output stage
//////////////////////////////

`timescale 1ns/1ps
`include "asg_defs.svh"

module asg_top import asg_pkg::*; (
  input  logic                 bus,
  input  logic                 arst_n,
  // apb slave
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [15:0]          paddr,
  input  asg_word_u            pwdata,
  output asg_word_u            prdata,
  output logic                 pready,
  output logic                 pslverr,
  // triggers
  input  logic [`ASG_TN-1:0]   trg_ext,
  output logic [`ASG_CH_N-1:0] trg_out,
  // dac stream
  output asg_smp_t             dac_dat [`ASG_CH_N],
  output logic [`ASG_CH_N-1:0] dac_vld
);

  // configuration from the register bank
  asg_trg_t cfg_trg [`ASG_CH_N];
  asg_ptr_t cfg_siz [`ASG_CH_N];
  asg_ptr_t cfg_off [`ASG_CH_N];
  asg_ptr_t cfg_stp [`ASG_CH_N];
  logic [`ASG_CH_N-1:0] cfg_wrap;
  asg_mul_t cfg_mul [`ASG_CH_N];
  asg_sum_t cfg_sum [`ASG_CH_N];
  // control pulses and table port
  logic [`ASG_CH_N-1:0] ctl_rst;
  logic [`ASG_CH_N-1:0] trg_sw;
  logic [`ASG_CH_N-1:0] buf_we;
  logic [`ASG_CWM-1:0] buf_addr;
  asg_smp_t buf_dat;
  // channel streams
  asg_smp_t smp [`ASG_CH_N];
  logic [`ASG_CH_N-1:0] smp_vld;

  asg_regs asg_regs_inst (
    .bus      (bus),
    .arst_n   (arst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .cfg_trg  (cfg_trg),
    .cfg_siz  (cfg_siz),
    .cfg_off  (cfg_off),
    .cfg_stp  (cfg_stp),
    .cfg_wrap (cfg_wrap),
    .cfg_mul  (cfg_mul),
    .cfg_sum  (cfg_sum),
    .ctl_rst  (ctl_rst),
    .trg_sw   (trg_sw),
    .buf_we   (buf_we),
    .buf_addr (buf_addr),
    .buf_dat  (buf_dat)
  );

  // identical playback channels
  for (genvar i = 0; i < `ASG_CH_N; i++) begin : g_ch
    asg_channel asg_channel_inst (
      .bus      (bus),
      .arst_n   (arst_n),
      .trg_ext  (trg_ext),
      .cfg_trg  (cfg_trg[i]),
      .cfg_siz  (cfg_siz[i]),
      .cfg_off  (cfg_off[i]),
      .cfg_stp  (cfg_stp[i]),
      .cfg_wrap (cfg_wrap[i]),
      .ctl_rst  (ctl_rst[i]),
      .trg_sw   (trg_sw[i]),
      .buf_we   (buf_we[i]),
      .buf_addr (buf_addr),
      .buf_dat  (buf_dat),
      .smp      (smp[i]),
      .smp_vld  (smp_vld[i]),
      .trg_out  (trg_out[i])
    );
  end

  asg_linear asg_linear_inst (
    .bus     (bus),
    .arst_n  (arst_n),
    .smp     (smp),
    .smp_vld (smp_vld),
    .cfg_mul (cfg_mul),
    .cfg_sum (cfg_sum),
    .dac_dat (dac_dat),
    .dac_vld (dac_vld)
  );

endmodule

//--- source/asg_linear.sv
//////////////////////////////
// signal generator output stage
// gain and offset per channel,
// saturated and registered
//////////////////////////////

`timescale 1ns/1ps
`include "asg_defs.svh"

module asg_linear import asg_pkg::*; (
  input  logic                 bus,
  input  logic                 arst_n,
  // channel samples
  input  asg_smp_t             smp [`ASG_CH_N],
  input  logic [`ASG_CH_N-1:0] smp_vld,
  // gain and offset
  input  asg_mul_t             cfg_mul [`ASG_CH_N],
  input  asg_sum_t             cfg_sum [`ASG_CH_N],
  // dac stream
  output asg_smp_t             dac_dat [`ASG_CH_N],
  output logic [`ASG_CH_N-1:0] dac_vld
);

  // full product width
  localparam int unsigned PW = `ASG_DW + `ASG_MW;
  // shift that takes unity gain back to one
  localparam int unsigned SH = `ASG_MW - 2;
  // scaled product plus offset, one guard bit
  localparam int unsigned SW = PW - SH + 1;

  for (genvar i = 0; i < `ASG_CH_N; i++) begin : g_ch
    logic signed [PW-1:0] prd;
    logic signed [PW-SH-1:0] shf;
    logic signed [SW-1:0] sum;
    logic sat;

    assign prd = smp[i] * cfg_mul[i];
    // arithmetic shift by dropping the low bits
    assign shf = prd[PW-1:SH];
    assign sum = shf + cfg_sum[i];

    // out of range when the top bits differ from the sign
    assign sat = (sum[SW-1:`ASG_DW-1] != {(SW - `ASG_DW + 1){sum[SW-1]}});

    always_ff @(posedge bus) begin
      if (sat) begin
        // clamp to the full scale limit of the sign
        dac_dat[i] <= {sum[SW-1], {(`ASG_DW - 1){~sum[SW-1]}}};
      end else begin
        dac_dat[i] <= sum[`ASG_DW-1:0];
      end
    end
  end

  // valid follows the data by the same register
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      dac_vld <= '0;
    end else begin
      dac_vld <= smp_vld;
    end
  end

endmodule

//--- source/asg_channel.sv
//////////////////////////////
// signal generator channel
// waveform table with fixed point
// read pointer, wrap or one shot
//////////////////////////////

`timescale 1ns/1ps
`include "asg_defs.svh"

module asg_channel import asg_pkg::*; (
  input  logic                bus,
  input  logic                arst_n,
  // external triggers
  input  logic [`ASG_TN-1:0]  trg_ext,
  // configuration
  input  asg_trg_t            cfg_trg,
  input  asg_ptr_t            cfg_siz,
  input  asg_ptr_t            cfg_off,
  input  asg_ptr_t            cfg_stp,
  input  logic                cfg_wrap,
  // software pulses
  input  logic                ctl_rst,
  input  logic                trg_sw,
  // table write port
  input  logic                buf_we,
  input  logic [`ASG_CWM-1:0] buf_addr,
  input  asg_smp_t            buf_dat,
  // sample stream
  output asg_smp_t            smp,
  output logic                smp_vld,
  // end of table pulse
  output logic                trg_out
);

  // waveform table
  asg_smp_t buf_mem [2**`ASG_CWM];

  // playback state
  logic run;
  asg_ptr_t ptr;

  // next pointer, one extra bit for the carry
  logic [`ASG_PW:0] ptr_sum;
  logic [`ASG_PW:0] ptr_wrp;
  logic ptr_end;

  // start condition
  logic trg;

  //////////////////////////////
  // trigger and pointer step
  //////////////////////////////

  // software or masked external, idle only
  assign trg = ~run & (trg_sw | (|(trg_ext & cfg_trg)));

  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg_stp};
  // end of table reached or passed
  assign ptr_end = (ptr_sum >= {1'b0, cfg_siz});
  // wrapped pointer keeps the overshoot
  assign ptr_wrp = ptr_sum - {1'b0, cfg_siz};

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      run <= 1'b0;
      ptr <= '0;
      smp_vld <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      // sample read this cycle is valid next cycle
      smp_vld <= run & ~ctl_rst;
      // aligned with the last sample before the wrap
      trg_out <= run & ~ctl_rst & ptr_end;
      if (ctl_rst) begin
        // abort playback at once
        run <= 1'b0;
      end else if (trg) begin
        // phase offset loads on trigger
        ptr <= cfg_off;
        run <= 1'b1;
      end else if (run) begin
        if (!ptr_end) begin
          ptr <= ptr_sum[`ASG_PW-1:0];
        end else if (cfg_wrap) begin
          ptr <= ptr_wrp[`ASG_PW-1:0];
        end else begin
          // one shot ends here
          run <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////
  // table storage
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (buf_we) begin
      buf_mem[buf_addr] <= buf_dat;
    end
    // integer part of the pointer addresses the table
    if (run) begin
      smp <= buf_mem[ptr[`ASG_CWF +: `ASG_CWM]];
    end
  end

endmodule

//--- source/asg_regs.sv
//////////////////////////////
// signal generator register bank
// APB slave with zero wait states,
// per channel config and table strobes
//////////////////////////////

`timescale 1ns/1ps
`include "asg_defs.svh"

module asg_regs import asg_pkg::*; (
  input  logic                 bus,
  input  logic                 arst_n,
  // apb slave
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [15:0]          paddr,
  input  asg_word_u            pwdata,
  output asg_word_u            prdata,
  output logic                 pready,
  output logic                 pslverr,
  // per channel configuration
  output asg_trg_t             cfg_trg [`ASG_CH_N],
  output asg_ptr_t             cfg_siz [`ASG_CH_N],
  output asg_ptr_t             cfg_off [`ASG_CH_N],
  output asg_ptr_t             cfg_stp [`ASG_CH_N],
  output logic [`ASG_CH_N-1:0] cfg_wrap,
  output asg_mul_t             cfg_mul [`ASG_CH_N],
  output asg_sum_t             cfg_sum [`ASG_CH_N],
  // one cycle control pulses
  output logic [`ASG_CH_N-1:0] ctl_rst,
  output logic [`ASG_CH_N-1:0] trg_sw,
  // table write port
  output logic [`ASG_CH_N-1:0] buf_we,
  output logic [`ASG_CWM-1:0]  buf_addr,
  output asg_smp_t             buf_dat
);

  // access cycle of a transfer
  logic acc;
  // full channel field and its decoded part
  logic [2:0] ch_idx;
  logic [`ASG_CH_AW-1:0] ch_sel;
  logic ch_ok;
  // table or register region
  logic tbl_sel;
  // word aligned register offset
  logic [11:0] reg_off;
  logic reg_hit;
  // accepted writes
  logic wr_ok;
  logic reg_wr;

  //////////////////////////////
  // address decode
  //////////////////////////////

  assign acc = psel & penable;

  // channel sits in paddr[15:13]
  assign ch_idx = paddr[15:13];
  assign ch_sel = ch_idx[`ASG_CH_AW-1:0];
  assign ch_ok = (ch_idx < 3'(`ASG_CH_N));

  assign tbl_sel = paddr[12];
  // byte lanes ignored
  assign reg_off = {paddr[11:2], 2'b00};

  // mapped register offsets
  always_comb begin
    case (reg_off)
      `ASG_REG_CTL,
      `ASG_REG_TRG,
      `ASG_REG_SIZ,
      `ASG_REG_OFF,
      `ASG_REG_STP,
      `ASG_REG_MOD,
      `ASG_REG_MUL,
      `ASG_REG_SUM: reg_hit = 1'b1;
      default:      reg_hit = 1'b0;
    endcase
  end

  // no wait states, every access cycle completes
  assign pready = acc;
  // bad channel, or unmapped offset in register region
  assign pslverr = acc & (~ch_ok | (~tbl_sel & ~reg_hit));

  assign wr_ok = acc & pwrite & ~pslverr;
  assign reg_wr = wr_ok & ~tbl_sel;

  //////////////////////////////
  // table writes and pulses
  //////////////////////////////

  // shared table address and data
  assign buf_addr = paddr[2 +: `ASG_CWM];
  assign buf_dat = pwdata.smp.dat;

  // strobes for the selected channel only
  always_comb begin
    ctl_rst = '0;
    trg_sw = '0;
    buf_we = '0;
    if (reg_wr && (reg_off == `ASG_REG_CTL)) begin
      ctl_rst[ch_sel] = pwdata.ctl.rst;
      trg_sw[ch_sel] = pwdata.ctl.trg;
    end
    if (wr_ok && tbl_sel) begin
      buf_we[ch_sel] = 1'b1;
    end
  end

  //////////////////////////////
  // configuration registers
  //////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `ASG_CH_N; i++) begin
        cfg_trg[i] <= '0;
        cfg_siz[i] <= '0;
        cfg_off[i] <= '0;
        cfg_stp[i] <= '0;
        // unity gain
        cfg_mul[i] <= asg_mul_t'(1 << (`ASG_MW - 2));
        cfg_sum[i] <= '0;
      end
      cfg_wrap <= '0;
    end else if (reg_wr) begin
      case (reg_off)
        `ASG_REG_TRG: cfg_trg[ch_sel] <= pwdata[`ASG_TN-1:0];
        `ASG_REG_SIZ: cfg_siz[ch_sel] <= pwdata[`ASG_PW-1:0];
        `ASG_REG_OFF: cfg_off[ch_sel] <= pwdata[`ASG_PW-1:0];
        `ASG_REG_STP: cfg_stp[ch_sel] <= pwdata[`ASG_PW-1:0];
        `ASG_REG_MOD: cfg_wrap[ch_sel] <= pwdata[0];
        `ASG_REG_MUL: cfg_mul[ch_sel] <= asg_mul_t'(pwdata[`ASG_MW-1:0]);
        // offset has the sample format
        `ASG_REG_SUM: cfg_sum[ch_sel] <= pwdata.smp.dat;
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // read back
  //////////////////////////////

  // table region and ctl read as zero
  always_comb begin
    prdata = '0;
    if (acc && !pwrite && ch_ok && !tbl_sel) begin
      case (reg_off)
        `ASG_REG_TRG: prdata = 32'(cfg_trg[ch_sel]);
        `ASG_REG_SIZ: prdata = 32'(cfg_siz[ch_sel]);
        `ASG_REG_OFF: prdata = 32'(cfg_off[ch_sel]);
        `ASG_REG_STP: prdata = 32'(cfg_stp[ch_sel]);
        `ASG_REG_MOD: prdata = 32'(cfg_wrap[ch_sel]);
        // signed, extended to the full word
        `ASG_REG_MUL: prdata = 32'(cfg_mul[ch_sel]);
        `ASG_REG_SUM: begin
          prdata.smp.rsv = {(32 - `ASG_DW){cfg_sum[ch_sel][`ASG_DW-1]}};
          prdata.smp.dat = cfg_sum[ch_sel];
        end
        default: prdata = '0;
      endcase
    end
  end

endmodule

//--- source/asg_pkg.sv
//////////////////////////////
// signal generator types
// samples, pointer fields and
// the two views of the APB word
//////////////////////////////

`include "asg_defs.svh"

package asg_pkg;

  // signed table and output sample
  typedef logic signed [`ASG_DW-1:0] asg_smp_t;

  // fixed point pointer, integer above fraction
  typedef logic [`ASG_PW-1:0] asg_ptr_t;

  // linear stage gain and offset
  typedef logic signed [`ASG_MW-1:0] asg_mul_t;
  typedef logic signed [`ASG_DW-1:0] asg_sum_t;

  // external trigger mask
  typedef logic [`ASG_TN-1:0] asg_trg_t;

  // control register view
  typedef struct packed {
    logic [29:0] rsv;
    logic        trg;
    logic        rst;
  } asg_ctl_t;

  // table word view, sample in low bits
  typedef struct packed {
    logic [31-`ASG_DW:0] rsv;
    asg_smp_t            dat;
  } asg_tbl_t;

  // apb data word, decoded by address region
  typedef union packed {
    asg_ctl_t ctl;
    asg_tbl_t smp;
  } asg_word_u;

endpackage

//--- include/asg_defs.svh
//////////////////////////////
// signal generator constants
// channel count, table geometry,
// data widths and register map
//////////////////////////////

`ifndef ASG_DEFS_SVH
`define ASG_DEFS_SVH

// number of playback channels
`define ASG_CH_N 2
// channel index bits decoded from paddr[13+]
`define ASG_CH_AW 1

// external trigger inputs
`define ASG_TN 2

// pointer integer part, 256 word table
`define ASG_CWM 8
// pointer fraction part
`define ASG_CWF 8
// full fixed point pointer width
`define ASG_PW (`ASG_CWM + `ASG_CWF)

// signed sample width, also the offset width
`define ASG_DW 14
// signed gain width, unity is 1 << (ASG_MW-2)
`define ASG_MW 16

//////////////////////////////
// register offsets inside a channel
//////////////////////////////

// control, write only pulses
`define ASG_REG_CTL 12'h000
// external trigger mask
`define ASG_REG_TRG 12'h004
// table size, offset and step
`define ASG_REG_SIZ 12'h010
`define ASG_REG_OFF 12'h014
`define ASG_REG_STP 12'h018
// playback mode, bit 0 is wrap
`define ASG_REG_MOD 12'h020
// linear stage gain and offset
`define ASG_REG_MUL 12'h030
`define ASG_REG_SUM 12'h034

`endif
